/* ctrl_trap_pkg.sv */
// trap side definitions of the core controller
// privilege levels, trap cause codes, interrupt vectors and the trap record
package ctrl_trap_pkg;

  // number of fast interrupt lines
  localparam int unsigned NUM_FAST_IRQ = 15;

  // data or address word
  typedef logic [31:0]             word_t;
  // one bit per fast interrupt line
  typedef logic [NUM_FAST_IRQ-1:0] fast_irq_t;
  // index of a fast interrupt line
  typedef logic [3:0]              fast_id_t;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // top bit set marks an interrupt, fast line n is {2'b11, n}
  typedef enum logic [5:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = 6'h00,
    EXC_CAUSE_INSTR_ACCESS_FAULT = 6'h01,
    EXC_CAUSE_ILLEGAL_INSN       = 6'h02,
    EXC_CAUSE_BREAKPOINT         = 6'h03,
    EXC_CAUSE_LOAD_ACCESS_FAULT  = 6'h05,
    EXC_CAUSE_STORE_ACCESS_FAULT = 6'h07,
    EXC_CAUSE_ECALL_UMODE        = 6'h08,
    EXC_CAUSE_ECALL_MMODE        = 6'h0b,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 6'h23,
    EXC_CAUSE_IRQ_TIMER_M        = 6'h27,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 6'h2b,
    EXC_CAUSE_IRQ_NM             = 6'h3f
  } exc_cause_e;

  // raw interrupt request lines
  typedef struct packed {
    logic      irq_software;
    logic      irq_timer;
    logic      irq_external;
    fast_irq_t irq_fast;
  } irqs_t;

  // exception record handed to the FSM in the flush cycle
  typedef struct packed {
    logic       req;
    exc_cause_e cause;
    word_t      tval;
  } trap_t;

endpackage

/* ctrl_pipe_pkg.sv */
// pipeline side definitions of the core controller
// fetch PC source, decoder flags and CSR save strobes
package ctrl_pipe_pkg;

  // source of the next fetch PC when a PC set is requested
  typedef enum logic [1:0] {
    PC_BOOT = 2'd0,
    PC_EXC  = 2'd1,
    PC_IRQ  = 2'd2,
    PC_ERET = 2'd3
  } pc_sel_e;

  // raw decoder flags, not yet qualified with instruction valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
  } dec_flags_t;

  // strobes toward the CSR file
  typedef struct packed {
    // save PC of the IF stage (interrupt entry)
    logic save_if;
    // save PC of the ID stage (exception entry)
    logic save_id;
    logic save_cause;
    logic restore_mret;
  } csr_save_t;

endpackage

/* exc_detect.sv */
// synchronous exception detection for the core controller
// qualifies decoder flags, flops the requests and builds cause and trap value
`timescale 1ns/1ps

module exc_detect
  import ctrl_trap_pkg::*;
  import ctrl_pipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // instruction in ID
  input  logic       instr_valid_i,
  input  dec_flags_t dec_i,
  input  logic       fetch_err_i,
  input  logic [1:0] lsu_err_i,
  input  priv_lvl_e  priv_i,
  input  word_t      instr_i,
  input  word_t      pc_i,
  input  word_t      lsu_addr_i,

  // from the FSM
  input  logic       in_flush_i,

  // to the FSM
  output logic       special_req_o,
  output logic       mret_o,
  output logic       wfi_o,
  output trap_t      trap_o
);

  logic ecall, ebrk, mret, wfi, fetch_err;
  logic illegal_umode;
  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_d, load_err_q;
  logic store_err_d, store_err_q;

  // decoder flags only count with a valid instruction
  assign ecall     = dec_i.ecall & instr_valid_i;
  assign ebrk      = dec_i.ebrk  & instr_valid_i;
  assign mret      = dec_i.mret  & instr_valid_i;
  assign wfi       = dec_i.wfi   & instr_valid_i;
  assign fetch_err = fetch_err_i & instr_valid_i;

  // MRET is M-mode only
  assign illegal_umode = (priv_i != PRIV_LVL_M) & mret;

  // requests drop while the FSM flushes so a handled one does not repeat
  assign illegal_d   = ((dec_i.illegal & instr_valid_i) | illegal_umode) & ~in_flush_i;
  assign exc_req_d   = (ecall | ebrk | illegal_d | fetch_err) & ~in_flush_i;
  // bit 0 is load, bit 1 is store
  assign load_err_d  = lsu_err_i[0] & ~in_flush_i;
  assign store_err_d = lsu_err_i[1] & ~in_flush_i;

  // LSU errors arrive without an ID valid
  assign special_req_o = mret | wfi | exc_req_d | (|lsu_err_i);
  assign mret_o        = mret;
  assign wfi_o         = wfi;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exc_req_q   <= 1'b0;
      illegal_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      exc_req_q   <= exc_req_d;
      illegal_q   <= illegal_d;
      load_err_q  <= load_err_d;
      store_err_q <= store_err_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // cause and trap value, priority as in the privileged spec
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    trap_o.req   = exc_req_q | store_err_q | load_err_q;
    trap_o.cause = EXC_CAUSE_INSN_ADDR_MISA;
    trap_o.tval  = '0;
    if (trap_o.req) begin
      if (fetch_err) begin
        trap_o.cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
        trap_o.tval  = pc_i;
      end else if (illegal_q) begin
        trap_o.cause = EXC_CAUSE_ILLEGAL_INSN;
        trap_o.tval  = instr_i;
      end else if (ecall) begin
        trap_o.cause = (priv_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
      end else if (ebrk) begin
        // plain breakpoint, trap value stays zero
        trap_o.cause = EXC_CAUSE_BREAKPOINT;
      end else if (store_err_q) begin
        trap_o.cause = EXC_CAUSE_STORE_ACCESS_FAULT;
        trap_o.tval  = lsu_addr_i;
      end else if (load_err_q) begin
        trap_o.cause = EXC_CAUSE_LOAD_ACCESS_FAULT;
        trap_o.tval  = lsu_addr_i;
      end
    end
  end

  // the FSM flushes in the cycle after a request, which clears it again
  a_exc_req_single : assert property (
    @(posedge clk_i) disable iff (!rst_ni) exc_req_q |=> !exc_req_q);

endmodule

/* irq_arbiter.sv */
// interrupt arbiter of the core controller
// decides whether an interrupt is taken and encodes its cause by priority
`timescale 1ns/1ps

module irq_arbiter
  import ctrl_trap_pkg::*;
(
  input  irqs_t      irqs_i,
  input  logic       irq_nm_i,
  // global M-mode interrupt enable
  input  logic       mie_i,
  // core is inside the NMI handler
  input  logic       nmi_mode_i,

  output logic       handle_irq_o,
  output exc_cause_e irq_cause_o
);

  logic     irq_pending;
  fast_id_t fast_id;

  // any line counts, the lines come qualified with mie CSR already
  assign irq_pending = |irqs_i;

  // no nesting in NMI mode, NMI itself bypasses mie
  assign handle_irq_o = ~nmi_mode_i & (irq_nm_i | (irq_pending & mie_i));

  //////////////////////////////////////////////////////////////////////
  // fast interrupt index
  //////////////////////////////////////////////////////////////////////

  // highest index wins, later iterations override earlier ones
  always_comb begin
    fast_id = '0;
    for (int unsigned i = 0; i < NUM_FAST_IRQ; i++) begin
      if (irqs_i.irq_fast[i]) begin
        fast_id = fast_id_t'(i);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // cause encoding
  //////////////////////////////////////////////////////////////////////

  // order is NMI, fast, external, software, timer
  always_comb begin
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (irqs_i.irq_fast != '0) begin
      // interrupt bit plus 16 on top of the fast index
      irq_cause_o = exc_cause_e'({2'b11, fast_id});
    end else if (irqs_i.irq_external) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.irq_software) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      // timer is left, or nothing pending at all
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // the NMI handler must never be entered twice
  always_comb begin
    a_no_irq_in_nmi : assert (!(handle_irq_o && nmi_mode_i));
  end

endmodule

/* ctrl_fsm.sv */
// controller state machine of the core
// steers boot, decode, flush, interrupt entry and sleep, keeps NMI mode
`timescale 1ns/1ps

module ctrl_fsm
  import ctrl_trap_pkg::*;
  import ctrl_pipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       fetch_enable_i,
  // ID stage cannot finish this cycle
  input  logic       stall_i,
  // any raw interrupt or NMI, wakes from sleep
  input  logic       irq_wake_i,

  // from exception detection
  input  logic       special_req_i,
  input  logic       mret_i,
  input  logic       wfi_i,
  input  trap_t      trap_i,

  // from the interrupt arbiter
  input  logic       handle_irq_i,
  input  exc_cause_e irq_cause_i,
  input  logic       irq_nm_i,

  output logic       in_flush_o,
  output logic       nmi_mode_o,

  // to fetch
  output logic       ctrl_busy_o,
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_sel_e    pc_mux_o,

  // to the CSR file
  output exc_cause_e exc_cause_o,
  output csr_save_t  csr_save_o,
  output word_t      csr_mtval_o,

  // to the IF/ID register
  output logic       id_in_ready_o,
  output logic       instr_valid_clear_o
);

  typedef enum logic [2:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN
  } ctrl_fsm_e;

  ctrl_fsm_e ctrl_fsm_cs, ctrl_fsm_ns;

  logic nmi_mode_d, nmi_mode_q;
  // keep IF from handing over a new instruction
  logic halt_if;
  // drop the instruction held in ID
  logic flush_id;

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_fsm_ns = ctrl_fsm_cs;
    nmi_mode_d  = nmi_mode_q;
    instr_req_o = 1'b1;
    ctrl_busy_o = 1'b1;
    pc_set_o    = 1'b0;
    // mux value only matters together with pc_set_o
    pc_mux_o    = PC_BOOT;
    exc_cause_o = EXC_CAUSE_INSN_ADDR_MISA;
    csr_save_o  = '0;
    csr_mtval_o = '0;
    halt_if     = 1'b0;
    flush_id    = 1'b0;

    unique case (ctrl_fsm_cs)
      RESET: begin
        // hold the boot address until fetch is enabled
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          ctrl_fsm_ns = BOOT_SET;
        end
      end

      BOOT_SET: begin
        pc_set_o    = 1'b1;
        ctrl_fsm_ns = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        ctrl_fsm_ns = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // clock may stay gated until some interrupt line shows up
        if (irq_wake_i) begin
          ctrl_fsm_ns = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait for the first instruction from IF
        if (id_in_ready_o) begin
          ctrl_fsm_ns = DECODE;
        end
        if (handle_irq_i) begin
          ctrl_fsm_ns = IRQ_TAKEN;
          halt_if     = 1'b1;
        end
      end

      DECODE: begin
        // special request keeps the instruction in ID for the flush cycle
        if (special_req_i) begin
          ctrl_fsm_ns = FLUSH;
          halt_if     = 1'b1;
        end
        // an interrupt waits for the running instruction to finish
        if (handle_irq_i && stall_i) begin
          halt_if = 1'b1;
        end
        if (!stall_i && !special_req_i && handle_irq_i) begin
          ctrl_fsm_ns = IRQ_TAKEN;
          halt_if     = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_mux_o = PC_IRQ;
        if (handle_irq_i) begin
          pc_set_o              = 1'b1;
          csr_save_o.save_if    = 1'b1;
          csr_save_o.save_cause = 1'b1;
          exc_cause_o           = irq_cause_i;
          // NMI entry, handler runs without further nesting
          if (irq_nm_i && !nmi_mode_q) begin
            nmi_mode_d = 1'b1;
          end
        end
        ctrl_fsm_ns = DECODE;
      end

      FLUSH: begin
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        ctrl_fsm_ns = DECODE;
        if (trap_i.req) begin
          // exception entry, PC of the faulting instruction goes to mepc
          pc_set_o              = 1'b1;
          pc_mux_o              = PC_EXC;
          csr_save_o.save_id    = 1'b1;
          csr_save_o.save_cause = 1'b1;
          exc_cause_o           = trap_i.cause;
          csr_mtval_o           = trap_i.tval;
        end else if (mret_i) begin
          pc_set_o                = 1'b1;
          pc_mux_o                = PC_ERET;
          csr_save_o.restore_mret = 1'b1;
          // leaving the NMI handler
          nmi_mode_d              = 1'b0;
        end else if (wfi_i) begin
          ctrl_fsm_ns = WAIT_SLEEP;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        ctrl_fsm_ns = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // stall control
  //////////////////////////////////////////////////////////////////////

  assign id_in_ready_o       = ~stall_i & ~halt_if;
  // halt_if keeps instr_valid unless ID is flushed as well
  assign instr_valid_clear_o = ~(stall_i | halt_if) | flush_id;

  assign in_flush_o = (ctrl_fsm_cs == FLUSH);
  assign nmi_mode_o = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_fsm_cs <= RESET;
      nmi_mode_q  <= 1'b0;
    end else begin
      ctrl_fsm_cs <= ctrl_fsm_ns;
      nmi_mode_q  <= nmi_mode_d;
    end
  end

  a_state_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ctrl_fsm_cs inside {RESET, BOOT_SET, WAIT_SLEEP, SLEEP,
                        FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN});

endmodule

/* core_ctrl.sv */
// core controller top level
// exception detection and interrupt arbiter side by side, both feeding the FSM
`timescale 1ns/1ps

module core_ctrl
  import ctrl_trap_pkg::*;
  import ctrl_pipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fetch_enable_i,

  // instruction in ID
  input  logic       instr_valid_i,
  input  dec_flags_t dec_i,
  input  logic       fetch_err_i,
  input  logic [1:0] lsu_err_i,
  input  priv_lvl_e  priv_i,
  input  word_t      instr_i,
  input  word_t      pc_i,
  input  word_t      lsu_addr_i,
  input  logic       stall_id_i,

  // interrupts
  input  irqs_t      irqs_i,
  input  logic       irq_nm_i,
  input  logic       csr_mstatus_mie_i,
  output logic       nmi_mode_o,

  // fetch control
  output logic       ctrl_busy_o,
  output logic       instr_req_o,
  output logic       pc_set_o,
  output pc_sel_e    pc_mux_o,

  // CSR file
  output exc_cause_e exc_cause_o,
  output csr_save_t  csr_save_o,
  output word_t      csr_mtval_o,

  // IF/ID register
  output logic       id_in_ready_o,
  output logic       instr_valid_clear_o
);

  logic       in_flush;
  logic       special_req;
  logic       mret;
  logic       wfi;
  trap_t      trap;
  logic       handle_irq;
  exc_cause_e irq_cause;
  logic       irq_wake;

  // sleep ends on any raw line, mie does not matter here
  assign irq_wake = irq_nm_i | (|irqs_i);

  exc_detect i_exc_detect (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .dec_i         (dec_i),
    .fetch_err_i   (fetch_err_i),
    .lsu_err_i     (lsu_err_i),
    .priv_i        (priv_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .lsu_addr_i    (lsu_addr_i),
    .in_flush_i    (in_flush),
    .special_req_o (special_req),
    .mret_o        (mret),
    .wfi_o         (wfi),
    .trap_o        (trap)
  );

  irq_arbiter i_irq_arbiter (
    .irqs_i       (irqs_i),
    .irq_nm_i     (irq_nm_i),
    .mie_i        (csr_mstatus_mie_i),
    .nmi_mode_i   (nmi_mode_o),
    .handle_irq_o (handle_irq),
    .irq_cause_o  (irq_cause)
  );

  ctrl_fsm i_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_enable_i      (fetch_enable_i),
    .stall_i             (stall_id_i),
    .irq_wake_i          (irq_wake),
    .special_req_i       (special_req),
    .mret_i              (mret),
    .wfi_i               (wfi),
    .trap_i              (trap),
    .handle_irq_i        (handle_irq),
    .irq_cause_i         (irq_cause),
    .irq_nm_i            (irq_nm_i),
    .in_flush_o          (in_flush),
    .nmi_mode_o          (nmi_mode_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .instr_req_o         (instr_req_o),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .exc_cause_o         (exc_cause_o),
    .csr_save_o          (csr_save_o),
    .csr_mtval_o         (csr_mtval_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o)
  );

endmodule

/* tb_clk_gen.sv */
// clock and reset source of the controller testbench
// 8 ns clock, active low reset held for the first two cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // half period of the 8 ns clock
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the DUT flops
  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* tb_core_ctrl.sv */
// testbench of the core controller
// directed tests for boot, exceptions, interrupts, NMI mode and WFI sleep
`timescale 1ns/1ps

module tb_core_ctrl
  import ctrl_trap_pkg::*;
  import ctrl_pipe_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic        fetch_enable;
  logic        instr_valid;
  dec_flags_t  dec;
  logic        fetch_err;
  logic [1:0]  lsu_err;
  priv_lvl_e   priv;
  word_t       instr;
  word_t       pc;
  word_t       lsu_addr;
  logic        stall_id;
  irqs_t       irqs;
  logic        irq_nm;
  logic        mie;
  logic        nmi_mode;
  logic        ctrl_busy;
  logic        instr_req;
  logic        pc_set;
  pc_sel_e     pc_mux;
  exc_cause_e  exc_cause;
  csr_save_t   csr_save;
  word_t       csr_mtval;
  logic        id_in_ready;
  logic        instr_valid_clear;

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  int          errors = 0;

  tb_clk_gen i_tb_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  core_ctrl i_core_ctrl (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .fetch_enable_i      (fetch_enable),
    .instr_valid_i       (instr_valid),
    .dec_i               (dec),
    .fetch_err_i         (fetch_err),
    .lsu_err_i           (lsu_err),
    .priv_i              (priv),
    .instr_i             (instr),
    .pc_i                (pc),
    .lsu_addr_i          (lsu_addr),
    .stall_id_i          (stall_id),
    .irqs_i              (irqs),
    .irq_nm_i            (irq_nm),
    .csr_mstatus_mie_i   (mie),
    .nmi_mode_o          (nmi_mode),
    .ctrl_busy_o         (ctrl_busy),
    .instr_req_o         (instr_req),
    .pc_set_o            (pc_set),
    .pc_mux_o            (pc_mux),
    .exc_cause_o         (exc_cause),
    .csr_save_o          (csr_save),
    .csr_mtval_o         (csr_mtval),
    .id_in_ready_o       (id_in_ready),
    .instr_valid_clear_o (instr_valid_clear)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // inputs change and outputs are sampled on the falling edge
  task automatic step();
    @(negedge clk);
  endtask

  task automatic stop_on_error(input string msg);
    errors++;
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      stop_on_error($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    end
  endtask

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // fresh PC, instruction word and LSU address for the next instruction
  task automatic new_operands();
    pc       = lcg_next() & 32'hffff_fffc;
    instr    = lcg_next();
    lsu_addr = lcg_next();
  endtask

  // nothing valid in ID, no errors, no interrupt lines
  task automatic drive_idle();
    instr_valid = 1'b0;
    dec         = '0;
    fetch_err   = 1'b0;
    lsu_err     = 2'b00;
    stall_id    = 1'b0;
    irqs        = '0;
    irq_nm      = 1'b0;
  endtask

  // upper LCG bits only, the low ones repeat quickly
  function automatic irqs_t random_irqs();
    word_t r;
    word_t s;
    irqs_t v;
    r = lcg_next();
    s = lcg_next();
    v.irq_software = s[29];
    v.irq_timer    = s[30];
    v.irq_external = s[31];
    // fast lines in about a quarter of the vectors
    v.irq_fast = (s[27:26] == 2'b00) ? r[30:16] : '0;
    if (v == '0) begin
      v.irq_timer = 1'b1;
    end
    return v;
  endfunction

  // layered from the lowest priority up, so the highest one set stays
  function automatic logic [5:0] irq_cause_of(input irqs_t v, input logic nmi);
    logic [5:0] cause;
    cause = 6'h27;
    if (v.irq_software) begin
      cause = 6'h23;
    end
    if (v.irq_external) begin
      cause = 6'h2b;
    end
    // fast line n is 16 + n with the interrupt bit, higher n wins
    for (int i = 0; i < 15; i++) begin
      if (v.irq_fast[i]) begin
        cause = 6'h30 + 6'(i);
      end
    end
    if (nmi) begin
      cause = 6'h3f;
    end
    return cause;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_boot();
    step();
    // still in RESET, boot address held
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_BOOT));
    check_val("instr_req_o", 32'(instr_req), 32'd0);
    check_val("ctrl_busy_o", 32'(ctrl_busy), 32'd1);
    check_val("exc_cause_o", 32'(exc_cause), 32'd0);
    check_val("csr_save_o", 32'(csr_save), 32'd0);
    check_val("nmi_mode_o", 32'(nmi_mode), 32'd0);
    fetch_enable = 1'b1;
    step();
    // BOOT_SET
    check_val("instr_req_o", 32'(instr_req), 32'd1);
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_BOOT));
    step();
    // FIRST_FETCH, IF hands over the first instruction
    check_val("pc_set_o", 32'(pc_set), 32'd0);
    check_val("id_in_ready_o", 32'(id_in_ready), 32'd1);
    step();
  endtask

  // one instruction in DECODE, then the flush cycle carries the trap
  task automatic run_exception(input string what, input dec_flags_t flags,
                               input logic ferr, input logic [1:0] lerr,
                               input priv_lvl_e lvl, input logic [5:0] exp_cause,
                               input word_t exp_tval);
    csr_save_t exp_save;
    exp_save            = '0;
    exp_save.save_id    = 1'b1;
    exp_save.save_cause = 1'b1;
    $display("exception: %s", what);
    instr_valid = (flags != '0) | ferr;
    dec         = flags;
    fetch_err   = ferr;
    lsu_err     = lerr;
    priv        = lvl;
    step();
    // instruction stays in ID through the flush
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_EXC));
    check_val("csr_save_o", 32'(csr_save), 32'(exp_save));
    check_val("exc_cause_o", 32'(exc_cause), 32'(exp_cause));
    check_val("csr_mtval_o", csr_mtval, exp_tval);
    check_val("instr_valid_clear_o", 32'(instr_valid_clear), 32'd1);
    step();
    check_val("pc_set_o", 32'(pc_set), 32'd0);
    drive_idle();
  endtask

  task automatic test_exceptions();
    dec_flags_t f;
    f         = '0;
    f.illegal = 1'b1;
    new_operands();
    run_exception("illegal instruction", f, 1'b0, 2'b00, PRIV_LVL_M, 6'h02, instr);
    f      = '0;
    f.mret = 1'b1;
    new_operands();
    run_exception("mret in U-mode", f, 1'b0, 2'b00, PRIV_LVL_U, 6'h02, instr);
    f       = '0;
    f.ecall = 1'b1;
    new_operands();
    run_exception("ecall in M-mode", f, 1'b0, 2'b00, PRIV_LVL_M, 6'h0b, 32'h0);
    new_operands();
    run_exception("ecall in U-mode", f, 1'b0, 2'b00, PRIV_LVL_U, 6'h08, 32'h0);
    f      = '0;
    f.ebrk = 1'b1;
    new_operands();
    run_exception("ebreak", f, 1'b0, 2'b00, PRIV_LVL_M, 6'h03, 32'h0);
    f = '0;
    new_operands();
    run_exception("fetch error", f, 1'b1, 2'b00, PRIV_LVL_M, 6'h01, pc);
    new_operands();
    run_exception("load fault", f, 1'b0, 2'b01, PRIV_LVL_M, 6'h05, lsu_addr);
    new_operands();
    run_exception("store fault", f, 1'b0, 2'b10, PRIV_LVL_M, 6'h07, lsu_addr);
  endtask

  task automatic test_irq_random();
    irqs_t     v;
    csr_save_t exp_save;
    exp_save            = '0;
    exp_save.save_if    = 1'b1;
    exp_save.save_cause = 1'b1;
    mie = 1'b1;
    for (int n = 0; n < 12; n++) begin
      v    = random_irqs();
      irqs = v;
      step();
      // IRQ_TAKEN
      check_val("pc_set_o", 32'(pc_set), 32'd1);
      check_val("pc_mux_o", 32'(pc_mux), 32'(PC_IRQ));
      check_val("csr_save_o", 32'(csr_save), 32'(exp_save));
      check_val("exc_cause_o", 32'(exc_cause), 32'(irq_cause_of(v, 1'b0)));
      step();
      check_val("pc_set_o", 32'(pc_set), 32'd0);
      irqs = '0;
    end
    mie = 1'b0;
  endtask

  task automatic test_irq_masked();
    mie  = 1'b0;
    irqs = '1;
    repeat (4) begin
      step();
      check_val("pc_set_o", 32'(pc_set), 32'd0);
      check_val("id_in_ready_o", 32'(id_in_ready), 32'd1);
    end
    irqs = '0;
  endtask

  task automatic test_irq_stall();
    csr_save_t exp_save;
    exp_save            = '0;
    exp_save.save_if    = 1'b1;
    exp_save.save_cause = 1'b1;
    mie            = 1'b1;
    stall_id       = 1'b1;
    irqs.irq_timer = 1'b1;
    repeat (3) begin
      step();
      check_val("pc_set_o", 32'(pc_set), 32'd0);
      check_val("id_in_ready_o", 32'(id_in_ready), 32'd0);
      check_val("instr_valid_clear_o", 32'(instr_valid_clear), 32'd0);
    end
    stall_id = 1'b0;
    step();
    // entry right after the stall ends
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_IRQ));
    check_val("exc_cause_o", 32'(exc_cause), 32'h27);
    check_val("csr_save_o", 32'(csr_save), 32'(exp_save));
    step();
    check_val("pc_set_o", 32'(pc_set), 32'd0);
    irqs = '0;
    mie  = 1'b0;
  endtask

  task automatic test_nmi();
    csr_save_t exp_save;
    exp_save            = '0;
    exp_save.save_if    = 1'b1;
    exp_save.save_cause = 1'b1;
    irq_nm = 1'b1;
    step();
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_IRQ));
    check_val("exc_cause_o", 32'(exc_cause), 32'(irq_cause_of(irqs, 1'b1)));
    check_val("csr_save_o", 32'(csr_save), 32'(exp_save));
    step();
    check_val("nmi_mode_o", 32'(nmi_mode), 32'd1);
    // no nesting, neither NMI nor enabled interrupts
    irq_nm            = 1'b1;
    mie               = 1'b1;
    irqs.irq_external = 1'b1;
    repeat (3) begin
      step();
      check_val("pc_set_o", 32'(pc_set), 32'd0);
      check_val("nmi_mode_o", 32'(nmi_mode), 32'd1);
    end
    drive_idle();
    mie         = 1'b0;
    // MRET from M-mode leaves the handler
    instr_valid = 1'b1;
    dec.mret    = 1'b1;
    priv        = PRIV_LVL_M;
    step();
    exp_save              = '0;
    exp_save.restore_mret = 1'b1;
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_ERET));
    check_val("csr_save_o", 32'(csr_save), 32'(exp_save));
    step();
    check_val("nmi_mode_o", 32'(nmi_mode), 32'd0);
    check_val("pc_set_o", 32'(pc_set), 32'd0);
    drive_idle();
  endtask

  task automatic wait_for_wake();
    int waited;
    waited = 0;
    step();
    while (!ctrl_busy && waited < 8) begin
      step();
      waited++;
    end
    assert (ctrl_busy) else begin
      stop_on_error("core stayed asleep after an interrupt line was raised");
    end
  endtask

  task automatic test_wfi();
    instr_valid = 1'b1;
    dec.wfi     = 1'b1;
    priv        = PRIV_LVL_M;
    step();
    // FLUSH, no PC change for WFI
    check_val("pc_set_o", 32'(pc_set), 32'd0);
    check_val("ctrl_busy_o", 32'(ctrl_busy), 32'd1);
    step();
    // WAIT_SLEEP, then SLEEP
    check_val("ctrl_busy_o", 32'(ctrl_busy), 32'd0);
    check_val("instr_req_o", 32'(instr_req), 32'd0);
    drive_idle();
    repeat (4) begin
      step();
      check_val("ctrl_busy_o", 32'(ctrl_busy), 32'd0);
      check_val("instr_req_o", 32'(instr_req), 32'd0);
    end
    // raw line wakes the core even with mie low
    irqs.irq_software = 1'b1;
    wait_for_wake();
    // FIRST_FETCH
    check_val("instr_req_o", 32'(instr_req), 32'd1);
    check_val("id_in_ready_o", 32'(id_in_ready), 32'd1);
    irqs = '0;
    step();
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  // the full sequence needs about 75 cycles
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= 400) begin
      $display("run did not finish within %0d cycles", cycle_cnt);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    lcg_state    = 32'h8d9e;
    fetch_enable = 1'b0;
    mie          = 1'b0;
    priv         = PRIV_LVL_M;
    instr        = '0;
    pc           = '0;
    lsu_addr     = '0;
    drive_idle();
    @(posedge rst_n);
    test_boot();
    test_exceptions();
    test_irq_random();
    test_irq_masked();
    test_irq_stall();
    test_nmi();
    test_wfi();
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
ctrl_trap_pkg.sv
ctrl_pipe_pkg.sv
exc_detect.sv
irq_arbiter.sv
ctrl_fsm.sv
core_ctrl.sv
tb_clk_gen.sv
tb_core_ctrl.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_core_ctrl
FILELIST = tb.f
BUILD    = obj_dir
SIM_BIN  = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
